// File: source/norm_corr_pkg.sv
package norm_corr_pkg;

   localparam int SAMPLE_W = 16;
   localparam int NORM_W   = 8;
   localparam int QUO_BITS = NORM_W - 1; // sign is applied after the divide.
   localparam int NUM_LAGS = 4;
   localparam int CNT_W    = 3;

   // raw input part.
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // magnitude or |re| + |im| + 1, needs one extra bit.
   typedef logic [SAMPLE_W:0] mag_t;

   typedef logic signed [NORM_W-1:0] norm_t;

   // 2 * 127 * 127 fits in 16 signed bits.
   typedef logic signed [2*NORM_W-1:0] corr_t;

   typedef enum logic [2:0]
   {
      IDLE,
      NORM,
      DIVIDE,
      SHIFT,
      CORR,
      HOLD
   } fsm_state_t;

endpackage

// File: source/norm_ctrl_if.sv
`timescale 1ns/1ps

interface norm_ctrl_if;

   logic load_en;  // capture sample, divisor and signs.
   logic div_step; // one quotient bit.
   logic shift_en; // advance the lag line.
   logic corr_en;  // register the lag results.

   modport ctrl
   (
      output load_en,
      output div_step,
      output shift_en,
      output corr_en
   );

   modport dp
   (
      input load_en,
      input div_step,
      input shift_en,
      input corr_en
   );

endinterface

// File: source/norm_fsm.sv
`timescale 1ns/1ps

module norm_fsm import norm_corr_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        in_valid,
   output logic        in_ready,
   output logic        out_valid,
   input  logic        out_ready,
   input  logic        last,
   output logic        start_cnt,
   norm_ctrl_if.ctrl   ctrl
);

   fsm_state_t state;
   fsm_state_t next_state;

   always_ff @(posedge clk)
   begin
      if (!rst)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (in_valid)
               next_state = NORM;
         end
         NORM:    next_state = DIVIDE;
         DIVIDE:
         begin
            if (last)
               next_state = SHIFT; // quotients settle during SHIFT.
         end
         SHIFT:   next_state = CORR;
         CORR:    next_state = HOLD;
         HOLD:
         begin
            if (out_ready)
               next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   assign in_ready  = (state == IDLE);
   assign out_valid = (state == HOLD);

   // one sample in flight, so accept only from IDLE.
   assign start_cnt     = in_ready && in_valid;
   assign ctrl.load_en  = in_ready && in_valid;
   assign ctrl.div_step = (state == DIVIDE);
   assign ctrl.shift_en = (state == SHIFT);
   assign ctrl.corr_en  = (state == CORR);

   a_ready_after_output: assert property (@(posedge clk) disable iff (!rst)
      $rose(in_ready) |-> $past(out_valid && out_ready));

   a_valid_after_corr: assert property (@(posedge clk) disable iff (!rst)
      $rose(out_valid) |-> $past(ctrl.corr_en));

endmodule

// File: source/iter_counter.sv
`timescale 1ns/1ps

module iter_counter import norm_corr_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic start_cnt,
   input  logic step,
   output logic last
);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk)
   begin
      if (!rst)
         cnt <= '0;
      else if (start_cnt)
         cnt <= CNT_W'(QUO_BITS);
      else if (step)
         cnt <= cnt - 1'b1;
   end

   assign last = (cnt == CNT_W'(1)); // final divide step.

   a_no_step_at_zero: assert property (@(posedge clk) disable iff (!rst)
      step |-> (cnt != '0));

endmodule

// File: source/frac_divider.sv
`timescale 1ns/1ps

module frac_divider import norm_corr_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                load,
   input  logic                step,
   input  mag_t                dividend,
   input  mag_t                divisor,
   output logic [QUO_BITS-1:0] quotient
);

   mag_t              rem;
   logic [SAMPLE_W+1:0] rem_dbl;
   logic [SAMPLE_W+1:0] diff;
   logic              take;

   // restoring step on the doubled remainder.
   assign rem_dbl = {rem, 1'b0};
   assign diff    = rem_dbl - {1'b0, divisor};
   assign take    = (rem_dbl >= {1'b0, divisor});

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         rem <= dividend; // dividend < divisor, so the result is a fraction.
      end
      else if (step)
      begin
         if (take)
            rem <= diff[SAMPLE_W:0];
         else
            rem <= rem_dbl[SAMPLE_W:0];
         quotient <= {quotient[QUO_BITS-2:0], take}; // msb first.
      end
   end

   a_rem_below_divisor: assert property (@(posedge clk) disable iff (!rst)
      (load || step) |=> (rem < divisor));

endmodule

// File: source/sample_normalizer.sv
`timescale 1ns/1ps

module sample_normalizer import norm_corr_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   norm_ctrl_if.dp   ctrl,
   input  sample_t   re_in,
   input  sample_t   im_in,
   output norm_t     re_out,
   output norm_t     im_out
);

   function automatic mag_t magnitude(input sample_t part);
      logic signed [SAMPLE_W:0] ext;
      ext = part;
      magnitude = (ext < 0) ? mag_t'(-ext) : mag_t'(ext);
   endfunction

   mag_t                re_mag;
   mag_t                im_mag;
   mag_t                divisor;
   logic                re_neg;
   logic                im_neg;
   logic [QUO_BITS-1:0] re_quo;
   logic [QUO_BITS-1:0] im_quo;

   assign re_mag = magnitude(re_in);
   assign im_mag = magnitude(im_in);

   always_ff @(posedge clk)
   begin
      if (ctrl.load_en)
      begin
         divisor <= re_mag + im_mag + 1'b1; // never zero.
         re_neg  <= re_in[SAMPLE_W-1];
         im_neg  <= im_in[SAMPLE_W-1];
      end
   end

   // magnitudes go straight into the divider remainders.
   frac_divider u_div_re (.clk(clk), .rst(rst), .load(ctrl.load_en), .step(ctrl.div_step),
                          .dividend(re_mag), .divisor(divisor), .quotient(re_quo));
   frac_divider u_div_im (.clk(clk), .rst(rst), .load(ctrl.load_en), .step(ctrl.div_step),
                          .dividend(im_mag), .divisor(divisor), .quotient(im_quo));

   assign re_out = re_neg ? -norm_t'({1'b0, re_quo}) : norm_t'({1'b0, re_quo});
   assign im_out = im_neg ? -norm_t'({1'b0, im_quo}) : norm_t'({1'b0, im_quo});

endmodule

// File: source/lag_correlator.sv
`timescale 1ns/1ps

module lag_correlator import norm_corr_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   norm_ctrl_if.dp                  ctrl,
   input  norm_t                    l_re,
   input  norm_t                    l_im,
   input  norm_t                    r_re,
   input  norm_t                    r_im,
   output corr_t [NUM_LAGS-1:0]     corr_out
);

   norm_t line_re [NUM_LAGS];
   norm_t line_im [NUM_LAGS];
   norm_t r_re_q;
   norm_t r_im_q;

   // entry 0 holds the newest left sample.
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         for (int k = 0; k < NUM_LAGS; k++)
         begin
            line_re[k] <= '0;
            line_im[k] <= '0;
         end
         r_re_q <= '0;
         r_im_q <= '0;
      end
      else if (ctrl.shift_en)
      begin
         line_re[0] <= l_re;
         line_im[0] <= l_im;
         for (int k = 1; k < NUM_LAGS; k++)
         begin
            line_re[k] <= line_re[k-1];
            line_im[k] <= line_im[k-1];
         end
         r_re_q <= r_re;
         r_im_q <= r_im;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
         corr_out <= '0;
      else if (ctrl.corr_en)
      begin
         for (int k = 0; k < NUM_LAGS; k++)
            corr_out[k] <= corr_t'(line_re[k]) * corr_t'(r_re_q)
                         + corr_t'(line_im[k]) * corr_t'(r_im_q);
      end
   end

endmodule

// File: source/norm_corr_top.sv
`timescale 1ns/1ps

module norm_corr_top import norm_corr_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  sample_t               l_re,
   input  sample_t               l_im,
   input  sample_t               r_re,
   input  sample_t               r_im,
   output logic                  out_valid,
   input  logic                  out_ready,
   output corr_t [NUM_LAGS-1:0]  corr_out
);

   logic  last;
   logic  start_cnt;
   norm_t l_re_n;
   norm_t l_im_n;
   norm_t r_re_n;
   norm_t r_im_n;

   norm_ctrl_if ctrl_bus ();

   norm_fsm u_fsm (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .last      (last),
      .start_cnt (start_cnt),
      .ctrl      (ctrl_bus.ctrl)
   );

   iter_counter u_cnt (.clk(clk), .rst(rst), .start_cnt(start_cnt),
                       .step(ctrl_bus.div_step), .last(last));

   // all four dividers run in lockstep off the same strobes.
   sample_normalizer u_norm_l (.clk(clk), .rst(rst), .ctrl(ctrl_bus.dp), .re_in(l_re),
                               .im_in(l_im), .re_out(l_re_n), .im_out(l_im_n));
   sample_normalizer u_norm_r (.clk(clk), .rst(rst), .ctrl(ctrl_bus.dp), .re_in(r_re),
                               .im_in(r_im), .re_out(r_re_n), .im_out(r_im_n));

   lag_correlator u_corr (
      .clk      (clk),
      .rst      (rst),
      .ctrl     (ctrl_bus.dp),
      .l_re     (l_re_n),
      .l_im     (l_im_n),
      .r_re     (r_re_n),
      .r_im     (r_im_n),
      .corr_out (corr_out)
   );

endmodule

// File: bench/norm_corr_tb.sv
`timescale 1ns/1ps

module norm_corr_tb import norm_corr_pkg::*;
();

   localparam int LATENCY    = 10; // NORM, 7 x DIVIDE, SHIFT, CORR.
   localparam int WAIT_LIMIT = 60;
   localparam int NUM_RANDOM = 12;

   logic                 clk;
   logic                 rst;
   logic                 in_valid;
   logic                 in_ready;
   sample_t              l_re;
   sample_t              l_im;
   sample_t              r_re;
   sample_t              r_im;
   logic                 out_valid;
   logic                 out_ready;
   corr_t [NUM_LAGS-1:0] corr_out;

   norm_t                model_re [NUM_LAGS]; // newest left sample at entry 0.
   norm_t                model_im [NUM_LAGS];
   corr_t [NUM_LAGS-1:0] exp_corr;
   corr_t [NUM_LAGS-1:0] prev_corr;
   logic                 pending;
   logic [4:0]           since_accept;
   sample_t              rand_smp [NUM_RANDOM][4];
   int                   stall [NUM_RANDOM];

   norm_corr_top dut_i (.clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
                        .l_re(l_re), .l_im(l_im), .r_re(r_re), .r_im(r_im),
                        .out_valid(out_valid), .out_ready(out_ready), .corr_out(corr_out));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int abs_value(input sample_t part);
      return (part < 0) ? -int'(part) : int'(part);
   endfunction

   // floor(128 * |part| / (|part| + |other| + 1)), then the sign of part.
   function automatic norm_t normalize_part(input sample_t part, input sample_t other);
      int quo;
      quo = (128 * abs_value(part)) / (abs_value(part) + abs_value(other) + 1);
      return (part < 0) ? norm_t'(-quo) : norm_t'(quo);
   endfunction

   function automatic corr_t lag_product(input norm_t a_re, input norm_t a_im,
                                         input norm_t b_re, input norm_t b_im);
      return corr_t'(int'(a_re) * int'(b_re) + int'(a_im) * int'(b_im));
   endfunction

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Verification failed");
      $fatal(1);
   endtask

   always @(posedge clk)
   begin
      if (!rst)
      begin
         model_re = '{default: '0};
         model_im = '{default: '0};
         exp_corr = '0;
      end
      else if (in_valid && in_ready)
      begin
         for (int k = NUM_LAGS - 1; k > 0; k--)
         begin
            model_re[k] = model_re[k-1];
            model_im[k] = model_im[k-1];
         end
         model_re[0] = normalize_part(l_re, l_im);
         model_im[0] = normalize_part(l_im, l_re);
         for (int k = 0; k < NUM_LAGS; k++)
            exp_corr[k] = lag_product(model_re[k], model_im[k], normalize_part(r_re, r_im),
                                      normalize_part(r_im, r_re));
      end
   end

   always @(posedge clk)
   begin
      prev_corr <= corr_out;
      if (!rst)
      begin
         pending      <= 1'b0;
         since_accept <= 5'd31; // saturated while nothing is accepted.
      end
      else if (in_valid && in_ready)
      begin
         pending      <= 1'b1;
         since_accept <= '0;
      end
      else
      begin
         if (out_valid && out_ready)
            pending <= 1'b0;
         if (since_accept != 5'd31)
            since_accept <= since_accept + 5'd1;
      end
   end

   a_reset_state: assert property (@(posedge clk) $rose(rst) |->
      (in_ready && !out_valid && corr_out == '0))
      else stop_on_error($sformatf(
         "FAIL in_ready/out_valid/corr_out after reset: got %h/%h/%h expected 1/0/0",
         $sampled(in_ready), $sampled(out_valid), $sampled(corr_out)));
   a_corr_value: assert property (@(posedge clk) disable iff (!rst)
      out_valid |-> (corr_out == exp_corr))
      else stop_on_error($sformatf("FAIL corr_out: got %h expected %h",
                                   $sampled(corr_out), $sampled(exp_corr)));
   a_latency: assert property (@(posedge clk) disable iff (!rst)
      $rose(out_valid) |-> (since_accept == 5'(LATENCY)))
      else stop_on_error($sformatf("FAIL out_valid latency: got %h cycles expected %h",
                                   $sampled(since_accept), 5'(LATENCY)));
   a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst)
      pending |-> !in_ready)
      else stop_on_error($sformatf("FAIL in_ready: got %h expected 0", $sampled(in_ready)));
   a_hold_valid: assert property (@(posedge clk) disable iff (!rst)
      (out_valid && !out_ready) |=> out_valid)
      else stop_on_error($sformatf("FAIL out_valid: got %h expected 1", $sampled(out_valid)));
   a_hold_data: assert property (@(posedge clk) disable iff (!rst)
      (out_valid && !out_ready) |=> (corr_out == prev_corr))
      else stop_on_error($sformatf("FAIL corr_out held: got %h expected %h",
                                   $sampled(corr_out), $sampled(prev_corr)));

   // called at a falling edge and leaves in_valid high after the transfer.
   task automatic send_sample(input sample_t lr, input sample_t li, input sample_t rr,
                              input sample_t ri);
      int waited = 0;
      in_valid = 1'b1;
      l_re     = lr;
      l_im     = li;
      r_re     = rr;
      r_im     = ri;
      while (!in_ready && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!in_ready)
         stop_on_error("input sample was never accepted");
      @(negedge clk);
   endtask

   task automatic take_output(input int hold);
      int waited = 0;
      out_ready = 1'b0;
      while (!out_valid && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!out_valid)
         stop_on_error("out_valid never rose after an accepted sample");
      repeat (hold) @(negedge clk); // back-pressure stretch.
      out_ready = 1'b1;
      @(negedge clk);
      out_ready = 1'b0;
   endtask

   task automatic run_single(input sample_t lr, input sample_t li, input sample_t rr,
                             input sample_t ri, input int hold);
      send_sample(lr, li, rr, ri);
      in_valid = 1'b0;
      take_output(hold);
   endtask

   initial
   begin
      void'($urandom(66));
      rst       = 1'b0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      l_re      = '0;
      l_im      = '0;
      r_re      = '0;
      r_im      = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
      @(negedge clk);

      // zero, mixed signs and both extremes.
      run_single(16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000, 0);
      run_single(16'sd1000, 16'sd2000, 16'sd300, -16'sd400, 0);
      run_single(-16'sd5000, 16'sd7000, -16'sd1, -16'sd1, 3);
      run_single(16'sh8000, 16'sh7FFF, 16'sh7FFF, 16'sh8000, 0);
      run_single(16'sh7FFF, 16'sh0000, 16'sh0000, 16'sh8000, 1);
      run_single(16'sh8000, 16'sh8000, 16'sd12345, 16'sh0000, 0);

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         for (int p = 0; p < 4; p++)
            rand_smp[i][p] = sample_t'($urandom);
         stall[i] = $urandom_range(0, 6);
      end
      fork
         begin
            for (int i = 0; i < NUM_RANDOM; i++)
               send_sample(rand_smp[i][0], rand_smp[i][1], rand_smp[i][2], rand_smp[i][3]);
            in_valid = 1'b0;
         end
         begin
            for (int i = 0; i < NUM_RANDOM; i++)
               take_output(stall[i]);
         end
      join
      @(negedge clk);
      $display("Verification passed");
      $finish;
   end

endmodule

// File: norm_corr_top.f
source/norm_corr_pkg.sv
source/norm_ctrl_if.sv
source/norm_fsm.sv
source/iter_counter.sv
source/frac_divider.sv
source/sample_normalizer.sv
source/lag_correlator.sv
source/norm_corr_top.sv
bench/norm_corr_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= norm_corr_tb
RTL_TOP   ?= norm_corr_top
FILELIST  ?= norm_corr_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
COMMON    ?= --timing --assert -Wno-fatal
SIM_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
